//--- soc_periph_pkg.sv
/*
 * Shared widths, address regions and control bit positions for the
 * game console peripheral block. Imported by the RTL and the testbench.
 */

package soc_periph_pkg;

    // CPU bus word and strobe widths
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = 4;

    // Region field sits at address bits 19:16
    localparam int REGION_LSB = 16;

    typedef enum logic [3:0] {
        REGION_NONE       = 4'd0,
        REGION_STATUS     = 4'd1,
        REGION_DSP        = 4'd2,
        REGION_PAD        = 4'd3,
        REGION_FLASH_CTRL = 4'd4
    } periph_region_t;

    // Flash control write word layout
    localparam int FLASH_IN_LSB     = 0;
    localparam int FLASH_IN_EN_LSB  = 4;
    localparam int FLASH_CLK_BIT    = 8;
    localparam int FLASH_CSN_BIT    = 9;
    localparam int FLASH_ACTIVE_BIT = 15;

    // Gamepad control write word layout
    localparam int PAD_LATCH_BIT = 0;
    localparam int PAD_CLK_BIT   = 1;

endpackage

//--- periph_bus_decoder.sv
/*
 * Front end of the peripheral bus. Captures the CPU request, decodes the
 * address region and issues one enable pulse per access, however long the
 * master holds valid.
 */

`timescale 1ns/10ps

module periph_bus_decoder
    import soc_periph_pkg::*;
#(
    parameter int ADDR_WIDTH = 24
) (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  mem_valid,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  logic [STRB_WIDTH-1:0] mem_wstrb,
    input  logic [DATA_WIDTH-1:0] mem_wdata,

    output logic                  status_write_en,
    output logic                  dsp_write_en,
    output logic                  pad_write_en,
    output logic                  flash_ctrl_write_en,
    output logic                  read_en,
    output periph_region_t        read_region,
    output logic                  access_en,
    output logic [DATA_WIDTH-1:0] write_data,
    output logic                  word_sel
);
    localparam int REGION_WIDTH = $bits(periph_region_t);

    logic                  req_valid;
    logic                  req_write;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [DATA_WIDTH-1:0] req_wdata;
    logic                  issued;
    logic                  fire;
    periph_region_t        req_region;

    assign req_region = periph_region_t'(req_addr[REGION_LSB +: REGION_WIDTH]);

    // First sampled cycle of a request that has not been served yet
    assign fire = req_valid && !issued;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= mem_valid;
        end
    end

    // Any strobe set means a write
    always_ff @(posedge vdp_clk) begin
        req_addr  <= mem_addr;
        req_write <= |mem_wstrb;
        req_wdata <= mem_wdata;
    end

    // Held until valid is seen low again
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            issued <= 1'b0;
        end else if (!req_valid) begin
            issued <= 1'b0;
        end else if (fire) begin
            issued <= 1'b1;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            access_en           <= 1'b0;
            read_en             <= 1'b0;
            status_write_en     <= 1'b0;
            dsp_write_en        <= 1'b0;
            pad_write_en        <= 1'b0;
            flash_ctrl_write_en <= 1'b0;
        end else begin
            access_en           <= fire;
            read_en             <= fire && !req_write;
            status_write_en     <= fire && req_write && (req_region == REGION_STATUS);
            dsp_write_en        <= fire && req_write && (req_region == REGION_DSP);
            pad_write_en        <= fire && req_write && (req_region == REGION_PAD);
            flash_ctrl_write_en <= fire && req_write && (req_region == REGION_FLASH_CTRL);
        end
    end

    // Stays stable for the peripherals while the pulse is out
    always_ff @(posedge vdp_clk) begin
        if (fire) begin
            write_data  <= req_wdata;
            word_sel    <= req_addr[2];
            read_region <= req_region;
        end
    end

endmodule

//--- periph_read_mux.sv
/*
 * Return path of the peripheral bus. Picks the read word of the addressed
 * region, zero-extends it and returns it with a one-cycle ready pulse.
 */

`timescale 1ns/10ps

module periph_read_mux
    import soc_periph_pkg::*;
(
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  access_en,
    input  logic                  read_en,
    input  periph_region_t        read_region,

    input  logic [DATA_WIDTH-1:0] dsp_read_data,
    input  logic                  pad_read_data,
    input  logic [3:0]            flash_ctrl_read_data,

    output logic                  mem_ready,
    output logic [DATA_WIDTH-1:0] mem_rdata
);
    logic [DATA_WIDTH-1:0] selected_data;

    always_comb begin
        case (read_region)
            REGION_DSP: begin
                selected_data = dsp_read_data;
            end
            REGION_PAD: begin
                selected_data = {{(DATA_WIDTH - 1){1'b0}}, pad_read_data};
            end
            REGION_FLASH_CTRL: begin
                selected_data = {{(DATA_WIDTH - 4){1'b0}}, flash_ctrl_read_data};
            end
            // Status is write-only, unmapped regions read zero
            default: begin
                selected_data = '0;
            end
        endcase
    end

    // Every access gets ready, mapped or not
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= access_en;
        end
    end

    // Writes return zero
    always_ff @(posedge vdp_clk) begin
        mem_rdata <= read_en ? selected_data : '0;
    end

endmodule

//--- dsp_multiplier.sv
/*
 * Memory-mapped signed multiplier. Word 0 sets operand A, word 1 sets
 * operand B, and reads return the product one cycle behind the operands.
 */

`timescale 1ns/10ps

module dsp_multiplier
    import soc_periph_pkg::*;
#(
    parameter int MULT_WIDTH = 16
) (
    input  logic                  vdp_clk,

    input  logic                  dsp_write_en,
    input  logic                  word_sel,
    input  logic [DATA_WIDTH-1:0] write_data,

    output logic [DATA_WIDTH-1:0] dsp_read_data
);
    logic [MULT_WIDTH-1:0] mult_a;
    logic [MULT_WIDTH-1:0] mult_b;

    always_ff @(posedge vdp_clk) begin
        if (dsp_write_en && !word_sel) begin
            mult_a <= write_data[MULT_WIDTH-1:0];
        end

        if (dsp_write_en && word_sel) begin
            mult_b <= write_data[MULT_WIDTH-1:0];
        end

        // Operands widen with sign to the result width
        dsp_read_data <= DATA_WIDTH'($signed(mult_a)) * DATA_WIDTH'($signed(mult_b));
    end

endmodule

//--- board_io.sv
/*
 * Board-level I/O. Holds the two status LEDs and emulates a serial gamepad
 * from the three board buttons, shifted out one bit per control clock.
 */

`timescale 1ns/10ps

module board_io
    import soc_periph_pkg::*;
(
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  status_write_en,
    input  logic                  pad_write_en,
    input  logic [DATA_WIDTH-1:0] write_data,

    input  logic                  btn_1,
    input  logic                  btn_2,
    input  logic                  btn_3,

    output logic                  led_r,
    output logic                  led_b,
    output logic                  pad_read_data
);
    logic [1:0]  status;
    logic        pad_latch;
    logic        pad_clk;
    logic        pad_clk_prev;
    logic [15:0] pad_shift;

    assign led_r = status[0];
    assign led_b = status[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= 2'b01;
        end else if (status_write_en) begin
            status <= write_data[1:0];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch    <= 1'b0;
            pad_clk      <= 1'b0;
            pad_clk_prev <= 1'b0;
        end else begin
            if (pad_write_en) begin
                pad_latch <= write_data[PAD_LATCH_BIT];
                pad_clk   <= write_data[PAD_CLK_BIT];
            end
            pad_clk_prev <= pad_clk;
        end
    end

    // B on bit 0, right on bit 6, left on bit 7
    always_ff @(posedge vdp_clk) begin
        if (pad_latch) begin
            pad_shift <= {8'b0, btn_1, btn_3, 5'b0, btn_2};
        end

        // Shift wins over a latch in the same cycle
        if (pad_clk && !pad_clk_prev) begin
            pad_shift <= {1'b0, pad_shift[15:1]};
        end
    end

    assign pad_read_data = pad_shift[0];

endmodule

//--- flash_ctrl_port.sv
/*
 * Bit-bang access to the SPI flash pins. While active the CPU drives clock,
 * select and data lines directly; otherwise the pins sit idle. The data
 * pins are sampled back every cycle for reads.
 */

`timescale 1ns/10ps

module flash_ctrl_port
    import soc_periph_pkg::*;
(
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    input  logic                  flash_ctrl_write_en,
    input  logic [DATA_WIDTH-1:0] write_data,
    input  logic [3:0]            flash_out,

    output logic                  flash_clk,
    output logic                  flash_csn,
    output logic [3:0]            flash_in,
    output logic [3:0]            flash_in_en,
    output logic [3:0]            flash_ctrl_read_data
);
    logic       ctrl_active;
    logic       ctrl_clk;
    logic       ctrl_csn;
    logic [3:0] ctrl_in;
    logic [3:0] ctrl_in_en;

    always_ff @(posedge vdp_clk) begin
        if (flash_ctrl_write_en) begin
            ctrl_in    <= write_data[FLASH_IN_LSB +: 4];
            ctrl_in_en <= write_data[FLASH_IN_EN_LSB +: 4];
            ctrl_clk   <= write_data[FLASH_CLK_BIT];
            ctrl_csn   <= write_data[FLASH_CSN_BIT];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ctrl_active <= 1'b0;
        end else if (flash_ctrl_write_en) begin
            ctrl_active <= write_data[FLASH_ACTIVE_BIT];
        end
    end

    // Idle: clock low, deselected, data lines released
    assign flash_clk   = ctrl_active ? ctrl_clk : 1'b0;
    assign flash_csn   = ctrl_active ? ctrl_csn : 1'b1;
    assign flash_in    = ctrl_active ? ctrl_in : 4'b0000;
    assign flash_in_en = ctrl_active ? ctrl_in_en : 4'b0000;

    always_ff @(posedge vdp_clk) begin
        flash_ctrl_read_data <= flash_out;
    end

endmodule

//--- soc_periph.sv
/*
 * Peripheral side of the console in the video clock domain. A CPU memory
 * bus reaches the status LEDs, the multiplier, the gamepad reader and the
 * flash bit-bang port. Every access completes two cycles after valid.
 */

`timescale 1ns/10ps

module soc_periph
    import soc_periph_pkg::*;
#(
    parameter int ADDR_WIDTH = 24,
    parameter int MULT_WIDTH = 16
) (
    input  logic                  vdp_clk,
    input  logic                  vdp_reset,

    // CPU bus
    input  logic                  mem_valid,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  logic [STRB_WIDTH-1:0] mem_wstrb,
    input  logic [DATA_WIDTH-1:0] mem_wdata,
    output logic                  mem_ready,
    output logic [DATA_WIDTH-1:0] mem_rdata,

    // Board buttons and LEDs
    input  logic                  btn_1,
    input  logic                  btn_2,
    input  logic                  btn_3,
    output logic                  led_r,
    output logic                  led_b,

    // Flash pins
    output logic                  flash_clk,
    output logic                  flash_csn,
    output logic [3:0]            flash_in,
    output logic [3:0]            flash_in_en,
    input  logic [3:0]            flash_out
);
    logic                  status_write_en;
    logic                  dsp_write_en;
    logic                  pad_write_en;
    logic                  flash_ctrl_write_en;
    logic                  read_en;
    logic                  access_en;
    periph_region_t        read_region;
    logic [DATA_WIDTH-1:0] write_data;
    logic                  word_sel;

    logic [DATA_WIDTH-1:0] dsp_read_data;
    logic                  pad_read_data;
    logic [3:0]            flash_ctrl_read_data;

    periph_bus_decoder #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_decoder (
        .vdp_clk            (vdp_clk),
        .vdp_reset          (vdp_reset),
        .mem_valid          (mem_valid),
        .mem_addr           (mem_addr),
        .mem_wstrb          (mem_wstrb),
        .mem_wdata          (mem_wdata),
        .status_write_en    (status_write_en),
        .dsp_write_en       (dsp_write_en),
        .pad_write_en       (pad_write_en),
        .flash_ctrl_write_en(flash_ctrl_write_en),
        .read_en            (read_en),
        .read_region        (read_region),
        .access_en          (access_en),
        .write_data         (write_data),
        .word_sel           (word_sel)
    );

    periph_read_mux u_read_mux (
        .vdp_clk             (vdp_clk),
        .vdp_reset           (vdp_reset),
        .access_en           (access_en),
        .read_en             (read_en),
        .read_region         (read_region),
        .dsp_read_data       (dsp_read_data),
        .pad_read_data       (pad_read_data),
        .flash_ctrl_read_data(flash_ctrl_read_data),
        .mem_ready           (mem_ready),
        .mem_rdata           (mem_rdata)
    );

    dsp_multiplier #(
        .MULT_WIDTH(MULT_WIDTH)
    ) u_dsp (
        .vdp_clk      (vdp_clk),
        .dsp_write_en (dsp_write_en),
        .word_sel     (word_sel),
        .write_data   (write_data),
        .dsp_read_data(dsp_read_data)
    );

    board_io u_board_io (
        .vdp_clk        (vdp_clk),
        .vdp_reset      (vdp_reset),
        .status_write_en(status_write_en),
        .pad_write_en   (pad_write_en),
        .write_data     (write_data),
        .btn_1          (btn_1),
        .btn_2          (btn_2),
        .btn_3          (btn_3),
        .led_r          (led_r),
        .led_b          (led_b),
        .pad_read_data  (pad_read_data)
    );

    flash_ctrl_port u_flash_ctrl (
        .vdp_clk             (vdp_clk),
        .vdp_reset           (vdp_reset),
        .flash_ctrl_write_en (flash_ctrl_write_en),
        .write_data          (write_data),
        .flash_out           (flash_out),
        .flash_clk           (flash_clk),
        .flash_csn           (flash_csn),
        .flash_in            (flash_in),
        .flash_in_en         (flash_in_en),
        .flash_ctrl_read_data(flash_ctrl_read_data)
    );

endmodule

//--- tb_soc_periph.sv
/*
 * Self-checking testbench for the console peripheral block. Drives the CPU
 * bus through every region with LFSR values, checks read data and pins with
 * immediate assertions and the ready timing with concurrent ones.
 */

`timescale 1ns/10ps

module tb_soc_periph
    import soc_periph_pkg::*;
();
    localparam int ADDR_WIDTH    = 24;
    localparam int CLK_PERIOD    = 10;
    localparam int READY_TIMEOUT = 20;
    // Generous bound per access, including the gap to the next one
    localparam int ACCESS_CYCLES = 10;
    localparam int WATCHDOG_NS   = 40 * ACCESS_CYCLES * CLK_PERIOD + 10000;

    logic                  vdp_clk = 1'b0;
    logic                  vdp_reset;
    logic                  mem_valid;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic [STRB_WIDTH-1:0] mem_wstrb;
    logic [DATA_WIDTH-1:0] mem_wdata;
    logic                  mem_ready;
    logic [DATA_WIDTH-1:0] mem_rdata;
    logic                  btn_1;
    logic                  btn_2;
    logic                  btn_3;
    logic                  led_r;
    logic                  led_b;
    logic                  flash_clk;
    logic                  flash_csn;
    logic [3:0]            flash_in;
    logic [3:0]            flash_in_en;
    logic [3:0]            flash_out;

    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    logic [15:0] lfsr_state  = 16'd54823;

    always #(CLK_PERIOD / 2) vdp_clk = ~vdp_clk;

    soc_periph u_soc_periph (
        .vdp_clk    (vdp_clk),
        .vdp_reset  (vdp_reset),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .mem_wstrb  (mem_wstrb),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .btn_1      (btn_1),
        .btn_2      (btn_2),
        .btn_3      (btn_3),
        .led_r      (led_r),
        .led_b      (led_b),
        .flash_clk  (flash_clk),
        .flash_csn  (flash_csn),
        .flash_in   (flash_in),
        .flash_in_en(flash_in_en),
        .flash_out  (flash_out)
    );

    // Valid first sampled at N gives ready sampled high at N+3
    ready_latency: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(mem_valid) |-> ##3 mem_ready)
    else begin
        error_count++;
        $display("Error [%0t] mem_ready missing two cycles after the request", $time);
    end

    no_early_ready: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(mem_valid) |-> ##2 !mem_ready)
    else begin
        error_count++;
        $display("Error [%0t] mem_ready arrived one cycle early", $time);
    end

    ready_pulse: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        mem_ready |=> !mem_ready)
    else begin
        error_count++;
        $display("Error [%0t] mem_ready stayed high for more than one cycle", $time);
    end

    // Taps 16, 14, 13, 11; one step per bit taken
    function automatic logic [31:0] take_random(input int nbits);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] region_addr(input logic [3:0] region,
                                                          input logic word);
        return {4'h0, region, 13'h0, word, 2'b00};
    endfunction

    task automatic expect_value(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Error [%0t] %s: got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic run_access(input logic [3:0] region, input logic word,
                              input logic [STRB_WIDTH-1:0] strb,
                              input logic [DATA_WIDTH-1:0] data,
                              output logic [DATA_WIDTH-1:0] rdata);
        int cycles;
        cycles = 0;
        @(posedge vdp_clk);
        mem_valid <= 1'b1;
        mem_addr  <= region_addr(region, word);
        mem_wstrb <= strb;
        mem_wdata <= data;
        @(posedge vdp_clk);
        while (!mem_ready && cycles < READY_TIMEOUT) begin
            cycles++;
            @(posedge vdp_clk);
        end
        if (!mem_ready) begin
            error_count++;
            $display("Access to region %0d got no ready within %0d cycles",
                     region, READY_TIMEOUT);
        end
        rdata = mem_rdata;
        mem_valid <= 1'b0;
        mem_wstrb <= '0;
    endtask

    task automatic write_word(input logic [3:0] region, input logic word,
                              input logic [31:0] data);
        logic [31:0] unused_rdata;
        run_access(region, word, 4'hf, data, unused_rdata);
    endtask

    task automatic read_word(input logic [3:0] region, input logic word,
                             output logic [31:0] data);
        run_access(region, word, 4'h0, 32'h0, data);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %s: PASS", name);
        end else begin
            $display("Test %s: FAIL with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic check_reset_state();
        expect_value(32'(mem_ready), 32'd0, "mem_ready after reset");
        expect_value(32'(led_r), 32'd1, "led_r after reset");
        expect_value(32'(led_b), 32'd0, "led_b after reset");
        expect_value(32'(flash_clk), 32'd0, "flash_clk after reset");
        expect_value(32'(flash_csn), 32'd1, "flash_csn after reset");
        expect_value(32'(flash_in), 32'd0, "flash_in after reset");
        expect_value(32'(flash_in_en), 32'd0, "flash_in_en after reset");
    endtask

    task automatic exercise_leds();
        logic [31:0] rdata;
        for (int value = 0; value < 4; value++) begin
            write_word(REGION_STATUS, 1'b0, 32'(value));
            expect_value(32'(led_r), 32'(value & 1), "led_r");
            expect_value(32'(led_b), 32'((value >> 1) & 1), "led_b");
        end
        // Write-only register
        read_word(REGION_STATUS, 1'b0, rdata);
        expect_value(rdata, 32'd0, "status read");
    endtask

    task automatic multiply_random();
        logic [15:0] op_a;
        logic [15:0] op_b;
        logic [31:0] rdata;
        int          product;
        for (int i = 0; i < 10; i++) begin
            op_a    = 16'(take_random(16));
            op_b    = 16'(take_random(16));
            product = int'($signed(op_a)) * int'($signed(op_b));
            // Upper bits are junk and must be ignored
            write_word(REGION_DSP, 1'b0, {16'(take_random(16)), op_a});
            write_word(REGION_DSP, 1'b1, {16'(take_random(16)), op_b});
            read_word(REGION_DSP, 1'b0, rdata);
            expect_value(rdata, product, "signed product");
        end
    endtask

    task automatic read_gamepad();
        logic [2:0]  buttons;
        logic [7:0]  pad_bits;
        logic [31:0] rdata;
        for (int round = 0; round < 3; round++) begin
            buttons = 3'(take_random(3));
            @(posedge vdp_clk);
            btn_1 <= buttons[0];
            btn_2 <= buttons[1];
            btn_3 <= buttons[2];
            // Load order: btn_2 first, btn_3 at 6, btn_1 at 7
            pad_bits = {buttons[0], buttons[2], 5'b0, buttons[1]};
            write_word(REGION_PAD, 1'b0, 32'd1 << PAD_LATCH_BIT);
            write_word(REGION_PAD, 1'b0, 32'd0);
            for (int bit_idx = 0; bit_idx < 8; bit_idx++) begin
                read_word(REGION_PAD, 1'b0, rdata);
                expect_value(rdata, {31'b0, pad_bits[bit_idx]}, "gamepad bit");
                write_word(REGION_PAD, 1'b0, 32'd1 << PAD_CLK_BIT);
                write_word(REGION_PAD, 1'b0, 32'd0);
            end
        end
    endtask

    task automatic bitbang_flash();
        logic [31:0] word;
        logic [31:0] rdata;
        logic [3:0]  pins;
        for (int round = 0; round < 4; round++) begin
            word = take_random(16) | (32'd1 << FLASH_ACTIVE_BIT);
            write_word(REGION_FLASH_CTRL, 1'b0, word);
            expect_value(32'(flash_in), 32'(word[FLASH_IN_LSB +: 4]), "flash_in");
            expect_value(32'(flash_in_en), 32'(word[FLASH_IN_EN_LSB +: 4]), "flash_in_en");
            expect_value(32'(flash_clk), 32'(word[FLASH_CLK_BIT]), "flash_clk");
            expect_value(32'(flash_csn), 32'(word[FLASH_CSN_BIT]), "flash_csn");
            pins = 4'(take_random(4));
            @(posedge vdp_clk);
            flash_out <= pins;
            read_word(REGION_FLASH_CTRL, 1'b0, rdata);
            expect_value(rdata, 32'(pins), "flash readback");
        end
        // Fields set but active clear, pins must go idle
        write_word(REGION_FLASH_CTRL, 1'b0, take_random(15));
        expect_value(32'(flash_clk), 32'd0, "idle flash_clk");
        expect_value(32'(flash_csn), 32'd1, "idle flash_csn");
        expect_value(32'(flash_in), 32'd0, "idle flash_in");
        expect_value(32'(flash_in_en), 32'd0, "idle flash_in_en");
    endtask

    task automatic probe_unmapped();
        logic [31:0] rdata;
        int          pulses;
        for (int round = 0; round < 4; round++) begin
            read_word(4'(5 + take_random(3)), 1'b0, rdata);
            expect_value(rdata, 32'd0, "unmapped read");
        end
        // Valid held well past ready
        pulses = 0;
        @(posedge vdp_clk);
        mem_valid <= 1'b1;
        mem_addr  <= region_addr(4'hf, 1'b0);
        mem_wstrb <= '0;
        repeat (8) begin
            @(posedge vdp_clk);
            if (mem_ready) pulses++;
        end
        mem_valid <= 1'b0;
        repeat (4) begin
            @(posedge vdp_clk);
            if (mem_ready) pulses++;
        end
        expect_value(32'(pulses), 32'd1, "ready pulses for a held request");
    endtask

    initial begin
        int errors_before;
        vdp_reset <= 1'b1;
        mem_valid <= 1'b0;
        mem_addr  <= '0;
        mem_wstrb <= '0;
        mem_wdata <= '0;
        btn_1     <= 1'b0;
        btn_2     <= 1'b0;
        btn_3     <= 1'b0;
        flash_out <= 4'h0;
        repeat (4) @(posedge vdp_clk);
        vdp_reset <= 1'b0;
        @(posedge vdp_clk);

        errors_before = error_count;
        check_reset_state();
        report_test("reset_state", errors_before);
        errors_before = error_count;
        exercise_leds();
        report_test("status_leds", errors_before);
        errors_before = error_count;
        multiply_random();
        report_test("multiplier", errors_before);
        errors_before = error_count;
        read_gamepad();
        report_test("gamepad", errors_before);
        errors_before = error_count;
        bitbang_flash();
        report_test("flash_bitbang", errors_before);
        errors_before = error_count;
        probe_unmapped();
        report_test("unmapped", errors_before);

        repeat (4) @(posedge vdp_clk);
        $display("Tests run: %0d, checks: %0d, errors: %0d",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- soc_periph.f
soc_periph_pkg.sv
periph_bus_decoder.sv
periph_read_mux.sv
dsp_multiplier.sv
board_io.sv
flash_ctrl_port.sv
soc_periph.sv
tb_soc_periph.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FILELIST  ?= soc_periph.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
